//--- link_pkg.sv
package link_pkg;

    typedef logic [3:0]  btype_t;
    typedef logic [11:0] buf_addr_t;
    typedef logic [11:0] dlen_t;
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Frame type codes, upper nibble of the header byte.
    localparam btype_t BT_INIT   = 4'd0;
    localparam btype_t BT_ACK    = 4'd1;
    localparam btype_t BT_NAK    = 4'd2;
    localparam btype_t BT_DIDX   = 4'd5;
    localparam btype_t BT_DPARAM = 4'd6;
    localparam btype_t BT_DDIDX  = 4'd7;
    localparam btype_t BT_LINK   = 4'd9;
    localparam btype_t BT_DATA0  = 4'd13;
    localparam btype_t BT_DATA1  = 4'd14;
    localparam btype_t BT_ERROR  = 4'd15;   // Checksum failure.

    localparam int BUF_DEPTH   = 64;
    localparam int BUF_AW      = $clog2(BUF_DEPTH);
    localparam int ANS_TIMEOUT = 128;       // Cycles.
    localparam int MAX_TRIES   = 10;

    // APB register map.
    localparam apb_addr_t REG_CTRL   = 12'h000;
    localparam apb_addr_t REG_BTYPE  = 12'h004;
    localparam apb_addr_t REG_DLEN   = 12'h008;
    localparam apb_addr_t REG_ADDR   = 12'h00C;
    localparam apb_addr_t REG_STATUS = 12'h010;
    localparam apb_addr_t TXBUF_BASE = 12'h100;
    localparam apb_addr_t RXBUF_BASE = 12'h200;

endpackage

//--- link_arq_ctrl.sv
`timescale 1ns/10ps

module link_arq_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                send_req,
    input  link_pkg::btype_t    send_btype,
    input  link_pkg::dlen_t     send_dlen,
    input  link_pkg::buf_addr_t send_addr,
    output logic                send_done,
    output logic                send_fail,
    output logic                read_valid,
    output link_pkg::btype_t    read_btype,
    input  logic                read_ack,
    output logic                tx_req,
    output link_pkg::btype_t    tx_btype,
    output link_pkg::buf_addr_t tx_addr,
    output link_pkg::dlen_t     tx_len,
    input  logic                tx_done,
    input  logic                rx_req,
    output logic                rx_ack,
    input  link_pkg::btype_t    rx_btype
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_WAIT,
        S_SEND_PREP,
        S_SEND_DATA,
        S_SEND_DONE,
        S_SEND_FAIL,
        S_RANS_WAIT,
        S_RANS_TOUT,
        S_RANS_TAKE,
        S_RANS_DONE,
        S_READ_PREP,
        S_READ_DATA,
        S_WANS_PREP,
        S_WANS_SEND,
        S_READ_DONE
    } arq_state_t;

    arq_state_t state;
    arq_state_t next_state;
    arq_state_t goto_state;     // Where to go once the answer handshake closes.

    logic [$clog2(link_pkg::ANS_TIMEOUT):0] timer;
    logic [$clog2(link_pkg::MAX_TRIES):0]   tries;
    logic                                    time_up;
    logic                                    last_try;
    logic                                    answerable;

    assign time_up  = timer >= link_pkg::ANS_TIMEOUT - 1;
    assign last_try = tries >= link_pkg::MAX_TRIES - 1;
    assign answerable = read_btype inside {link_pkg::BT_DIDX, link_pkg::BT_DPARAM,
                                           link_pkg::BT_DDIDX, link_pkg::BT_LINK,
                                           link_pkg::BT_ERROR};

    assign send_done  = (state == S_SEND_DONE) || (state == S_SEND_FAIL);
    assign send_fail  = state == S_SEND_FAIL;
    assign read_valid = state == S_READ_DONE;
    assign tx_req     = (state == S_SEND_DATA) || (state == S_WANS_SEND);
    assign rx_ack     = (state == S_RANS_DONE) || (state == S_READ_DATA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:      next_state = S_WAIT;
            S_WAIT: begin
                if (send_req) next_state = S_SEND_PREP;     // Send wins over receive.
                else if (rx_req) next_state = S_READ_PREP;
            end
            S_SEND_PREP: next_state = S_SEND_DATA;
            S_SEND_DATA: if (tx_done) next_state = S_RANS_WAIT;
            S_RANS_WAIT: begin
                if (time_up) next_state = S_RANS_TOUT;
                else if (rx_req) next_state = S_RANS_TAKE;
            end
            S_RANS_TOUT: next_state = last_try ? S_SEND_FAIL : S_SEND_DATA;
            S_RANS_TAKE: next_state = S_RANS_DONE;
            S_RANS_DONE: if (!rx_req) next_state = goto_state;
            S_SEND_DONE: if (!send_req) next_state = S_WAIT;
            S_SEND_FAIL: if (!send_req) next_state = S_WAIT;
            S_READ_PREP: next_state = S_READ_DATA;
            S_READ_DATA: if (!rx_req) next_state = S_WANS_PREP;
            S_WANS_PREP: next_state = answerable ? S_WANS_SEND : S_WAIT;
            S_WANS_SEND: if (tx_done) next_state = S_READ_DONE;
            S_READ_DONE: if (read_ack || time_up) next_state = S_WAIT;
            default:     next_state = S_IDLE;
        endcase
    end

    // Answer decision, taken while the peer's frame is still presented.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            goto_state <= S_IDLE;
        end else if (state == S_RANS_TAKE) begin
            // ACK and any type other than NAK complete the send.
            if (rx_btype != link_pkg::BT_NAK) goto_state <= S_SEND_DONE;
            else if (last_try) goto_state <= S_SEND_FAIL;
            else goto_state <= S_SEND_DATA;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_btype   <= link_pkg::BT_INIT;
            tx_addr    <= '0;
            tx_len     <= '0;
            read_btype <= link_pkg::BT_INIT;
        end else begin
            case (state)
                S_WAIT: read_btype <= link_pkg::BT_INIT;
                S_SEND_PREP: begin
                    tx_btype <= send_btype;
                    tx_addr  <= send_addr;
                    tx_len   <= send_dlen;
                end
                S_READ_PREP: read_btype <= rx_btype;
                S_WANS_PREP: begin
                    tx_btype <= (read_btype == link_pkg::BT_ERROR) ? link_pkg::BT_NAK
                                                                   : link_pkg::BT_ACK;
                    tx_addr  <= '0;
                    tx_len   <= '0;     // Answers carry no payload.
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer <= '0;
            tries <= '0;
        end else begin
            if (state == S_RANS_WAIT || state == S_READ_DONE) timer <= timer + 1'b1;
            else timer <= '0;
            if (state == S_WAIT) tries <= '0;
            else if (state == S_RANS_TOUT || state == S_RANS_TAKE) tries <= tries + 1'b1;
        end
    end

endmodule

//--- link_tx_framer.sv
`timescale 1ns/10ps

module link_tx_framer (
    input  logic                clk,
    input  logic                rst,
    input  logic                tx_req,
    input  link_pkg::btype_t    tx_btype,
    input  link_pkg::buf_addr_t tx_addr,
    input  link_pkg::dlen_t     tx_len,
    output logic                tx_done,
    output link_pkg::buf_addr_t txbuf_addr,
    input  link_pkg::byte_t     txbuf_data,
    output link_pkg::byte_t     tx_data,
    output logic                tx_valid,
    input  logic                tx_ready
);

    typedef enum logic [2:0] {F_IDLE, F_HDR, F_LEN, F_PAY, F_CSUM, F_DONE} fr_state_t;

    fr_state_t       state;
    link_pkg::dlen_t idx;       // Payload byte index.
    link_pkg::byte_t csum;
    logic            xfer;

    assign xfer       = tx_valid && tx_ready;
    assign tx_valid   = state inside {F_HDR, F_LEN, F_PAY, F_CSUM};
    assign tx_done    = state == F_DONE;
    assign txbuf_addr = link_pkg::buf_addr_t'((tx_addr + idx) % link_pkg::BUF_DEPTH);

    // Inputs are stable during a request, so the byte holds under back-pressure.
    always_comb begin
        case (state)
            F_HDR:   tx_data = {tx_btype, tx_len[11:8]};
            F_LEN:   tx_data = tx_len[7:0];
            F_PAY:   tx_data = txbuf_data;
            F_CSUM:  tx_data = csum;
            default: tx_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= F_IDLE;
            idx   <= '0;
            csum  <= '0;
        end else begin
            if (xfer && state != F_CSUM) csum <= csum ^ tx_data;
            case (state)
                F_IDLE: begin
                    idx  <= '0;
                    csum <= '0;
                    if (tx_req) state <= F_HDR;
                end
                F_HDR: if (xfer) state <= F_LEN;
                F_LEN: if (xfer) state <= (tx_len == '0) ? F_CSUM : F_PAY;
                F_PAY: begin
                    if (xfer) begin
                        idx <= idx + 1'b1;
                        if (idx == tx_len - 1'b1) state <= F_CSUM;
                    end
                end
                F_CSUM: if (xfer) state <= F_DONE;
                F_DONE: if (!tx_req) state <= F_IDLE;   // Four-phase release.
                default: state <= F_IDLE;
            endcase
        end
    end

endmodule

//--- link_rx_parser.sv
`timescale 1ns/10ps

module link_rx_parser (
    input  logic                clk,
    input  logic                rst,
    input  link_pkg::byte_t     rx_data,
    input  logic                rx_valid,
    output logic                rx_req,
    input  logic                rx_ack,
    output link_pkg::btype_t    rx_btype,
    output logic                rxbuf_we,
    output link_pkg::buf_addr_t rxbuf_addr,
    output link_pkg::byte_t     rxbuf_data
);

    typedef enum logic [2:0] {P_HDR, P_LEN, P_PAY, P_CSUM, P_REQ, P_REL} ps_state_t;

    ps_state_t        state;
    link_pkg::btype_t hdr_btype;
    link_pkg::dlen_t  len;
    link_pkg::dlen_t  idx;
    link_pkg::byte_t  csum;     // Running XOR of the frame so far.

    assign rx_req     = state == P_REQ;
    assign rxbuf_we   = (state == P_PAY) && rx_valid;
    assign rxbuf_addr = link_pkg::buf_addr_t'(idx % link_pkg::BUF_DEPTH);
    assign rxbuf_data = rx_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= P_HDR;
            hdr_btype <= link_pkg::BT_INIT;
            len       <= '0;
            idx       <= '0;
            csum      <= '0;
            rx_btype  <= link_pkg::BT_INIT;
        end else begin
            case (state)
                P_HDR: begin
                    if (rx_valid) begin
                        hdr_btype  <= rx_data[7:4];
                        len[11:8]  <= rx_data[3:0];
                        csum       <= rx_data;
                        state      <= P_LEN;
                    end
                end
                P_LEN: begin
                    if (rx_valid) begin
                        len[7:0] <= rx_data;
                        csum     <= csum ^ rx_data;
                        idx      <= '0;
                        state    <= ({len[11:8], rx_data} == '0) ? P_CSUM : P_PAY;
                    end
                end
                P_PAY: begin
                    if (rx_valid) begin
                        csum <= csum ^ rx_data;
                        idx  <= idx + 1'b1;
                        if (idx == len - 1'b1) state <= P_CSUM;
                    end
                end
                P_CSUM: begin
                    if (rx_valid) begin
                        rx_btype <= (rx_data == csum) ? hdr_btype : link_pkg::BT_ERROR;
                        state    <= P_REQ;
                    end
                end
                P_REQ: if (rx_ack) state <= P_REL;
                P_REL: if (!rx_ack) state <= P_HDR;    // Bytes seen here are dropped.
                default: state <= P_HDR;
            endcase
        end
    end

endmodule

//--- link_apb_regs.sv
`timescale 1ns/10ps

module link_apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  link_pkg::apb_addr_t   paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  link_pkg::apb_data_t   pwdata,
    output link_pkg::apb_data_t   prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  link_pkg::buf_addr_t   txbuf_addr,
    output link_pkg::byte_t       txbuf_data,
    input  logic                  rxbuf_we,
    input  link_pkg::buf_addr_t   rxbuf_addr,
    input  link_pkg::byte_t       rxbuf_data,
    output logic                  send_req,
    output link_pkg::btype_t      send_btype,
    output link_pkg::dlen_t       send_dlen,
    output link_pkg::buf_addr_t   send_addr,
    input  logic                  send_done,
    input  logic                  send_fail,
    input  logic                  read_valid,
    input  link_pkg::btype_t      read_btype,
    output logic                  read_ack
);

    link_pkg::byte_t             txbuf [link_pkg::BUF_DEPTH];
    link_pkg::byte_t             rxbuf [link_pkg::BUF_DEPTH];
    logic                        done_flag;
    logic                        fail_flag;
    logic                        wr_en;
    logic                        wr_ctrl;
    logic                        is_reg;
    logic                        is_txbuf;
    logic                        is_rxbuf;
    logic [link_pkg::BUF_AW-1:0] buf_idx;

    assign wr_en    = psel && penable && pwrite;
    assign wr_ctrl  = wr_en && (paddr == link_pkg::REG_CTRL);
    assign is_reg   = paddr inside {link_pkg::REG_CTRL, link_pkg::REG_BTYPE, link_pkg::REG_DLEN,
                                    link_pkg::REG_ADDR, link_pkg::REG_STATUS};
    assign is_txbuf = paddr[11:8] == link_pkg::TXBUF_BASE[11:8];
    assign is_rxbuf = paddr[11:8] == link_pkg::RXBUF_BASE[11:8];
    assign buf_idx  = paddr[link_pkg::BUF_AW+1:2];      // One byte per word.

    assign pready     = 1'b1;
    assign pslverr    = psel && penable && !(is_reg || is_txbuf || is_rxbuf);
    assign txbuf_data = txbuf[txbuf_addr[link_pkg::BUF_AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en && is_txbuf) txbuf[buf_idx] <= pwdata[7:0];
        if (rxbuf_we) rxbuf[rxbuf_addr[link_pkg::BUF_AW-1:0]] <= rxbuf_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_req   <= 1'b0;
            done_flag  <= 1'b0;
            fail_flag  <= 1'b0;
            read_ack   <= 1'b0;
            send_btype <= link_pkg::BT_INIT;
            send_dlen  <= '0;
            send_addr  <= '0;
        end else begin
            read_ack <= wr_ctrl && pwdata[1] && read_valid;
            if (send_done) begin
                send_req  <= 1'b0;
                done_flag <= 1'b1;
                fail_flag <= send_fail;
            end else if (wr_ctrl && pwdata[0]) begin
                send_req  <= 1'b1;     // A new start clears the sticky bits.
                done_flag <= 1'b0;
                fail_flag <= 1'b0;
            end
            if (wr_en && paddr == link_pkg::REG_BTYPE) send_btype <= pwdata[3:0];
            if (wr_en && paddr == link_pkg::REG_DLEN) send_dlen <= pwdata[11:0];
            if (wr_en && paddr == link_pkg::REG_ADDR) send_addr <= pwdata[11:0];
        end
    end

    always_comb begin
        prdata = '0;
        if (is_txbuf) prdata = link_pkg::apb_data_t'(txbuf[buf_idx]);
        else if (is_rxbuf) prdata = link_pkg::apb_data_t'(rxbuf[buf_idx]);
        else if (paddr == link_pkg::REG_CTRL) prdata = link_pkg::apb_data_t'(send_req);
        else if (paddr == link_pkg::REG_BTYPE) prdata = link_pkg::apb_data_t'(send_btype);
        else if (paddr == link_pkg::REG_DLEN) prdata = link_pkg::apb_data_t'(send_dlen);
        else if (paddr == link_pkg::REG_ADDR) prdata = link_pkg::apb_data_t'(send_addr);
        else if (paddr == link_pkg::REG_STATUS)
            prdata = link_pkg::apb_data_t'({read_btype, read_valid, fail_flag, done_flag,
                                            send_req});
    end

endmodule

//--- link_top.sv
`timescale 1ns/10ps

module link_top (
    input  logic                clk,
    input  logic                rst,
    input  link_pkg::apb_addr_t paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  link_pkg::apb_data_t pwdata,
    output link_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    output link_pkg::byte_t     tx_data,
    output logic                tx_valid,
    input  logic                tx_ready,
    input  link_pkg::byte_t     rx_data,
    input  logic                rx_valid
);

    logic                send_req, send_done, send_fail;
    logic                read_valid, read_ack;
    logic                tx_req, tx_done, rx_req, rx_ack, rxbuf_we;
    link_pkg::btype_t    send_btype, read_btype, tx_btype, rx_btype;
    link_pkg::dlen_t     send_dlen, tx_len;
    link_pkg::buf_addr_t send_addr, tx_addr, txbuf_addr, rxbuf_addr;
    link_pkg::byte_t     txbuf_data, rxbuf_data;

    link_apb_regs u_regs (
        .clk, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .txbuf_addr, .txbuf_data,
        .rxbuf_we, .rxbuf_addr, .rxbuf_data,
        .send_req, .send_btype, .send_dlen, .send_addr, .send_done, .send_fail,
        .read_valid, .read_btype, .read_ack
    );

    link_arq_ctrl u_ctrl (
        .clk, .rst,
        .send_req, .send_btype, .send_dlen, .send_addr, .send_done, .send_fail,
        .read_valid, .read_btype, .read_ack,
        .tx_req, .tx_btype, .tx_addr, .tx_len, .tx_done,
        .rx_req, .rx_ack, .rx_btype
    );

    link_tx_framer u_framer (
        .clk, .rst,
        .tx_req, .tx_btype, .tx_addr, .tx_len, .tx_done,
        .txbuf_addr, .txbuf_data,
        .tx_data, .tx_valid, .tx_ready
    );

    link_rx_parser u_parser (
        .clk, .rst,
        .rx_data, .rx_valid,
        .rx_req, .rx_ack, .rx_btype,
        .rxbuf_we, .rxbuf_addr, .rxbuf_data
    );

endmodule

//--- link_assertions.sv
`timescale 1ns/10ps

module link_assertions (
    input logic            clk,
    input logic            rst,
    input logic            psel,
    input logic            penable,
    input logic            pslverr,
    input logic            send_done,
    input logic            send_fail,
    input logic            tx_req,
    input logic            rx_ack,
    input logic            tx_valid,
    input logic            tx_ready,
    input link_pkg::byte_t tx_data
);

    int err_cnt = 0;

    a_pslverr_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable)
        else begin
            $error("pslverr outside an APB access phase");
            err_cnt++;
        end

    a_fail_done: assert property (@(posedge clk) disable iff (rst)
        send_fail |-> send_done)
        else begin
            $error("send_fail without send_done");
            err_cnt++;
        end

    // Byte must hold while the peer stalls.
    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else begin
            $error("tx byte changed under back-pressure");
            err_cnt++;
        end

    a_req_ack: assert property (@(posedge clk) disable iff (rst)
        !(tx_req && rx_ack))
        else begin
            $error("tx_req and rx_ack high together");
            err_cnt++;
        end

endmodule

bind link_top link_assertions u_assertions (.*);

//--- link_tb.sv
`timescale 1ns/10ps

module link_tb;

    logic                clk;
    logic                rst;
    link_pkg::apb_addr_t paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    link_pkg::apb_data_t pwdata;
    link_pkg::apb_data_t prdata;
    logic                pready;
    logic                pslverr;
    link_pkg::byte_t     tx_data;
    logic                tx_valid;
    logic                tx_ready;
    link_pkg::byte_t     rx_data;
    logic                rx_valid;

    integer              seed = 32'h0a9b8f37;
    int                  fails = 0;
    int                  test_errs = 0;
    int                  n_tests = 0;
    int                  frames = 0;        // Frames captured from the DUT.
    int                  byte_cnt = 0;
    int                  ready_cnt = 0;
    link_pkg::byte_t     acc;
    link_pkg::btype_t    cap_btype;
    link_pkg::dlen_t     cap_len;
    link_pkg::byte_t     cap_pay [link_pkg::BUF_DEPTH];
    link_pkg::byte_t     tx_model [link_pkg::BUF_DEPTH];
    link_pkg::byte_t     rx_model [link_pkg::BUF_DEPTH];
    link_pkg::btype_t    exp_btype;
    link_pkg::dlen_t     exp_len;
    link_pkg::buf_addr_t exp_addr;

    link_top DUT (.*);

    always #10 clk = ~clk;

    // Peer stalls one cycle in three.
    always @(posedge clk) begin
        #1;
        ready_cnt = ready_cnt + 1;
        tx_ready = (ready_cnt % 3) != 0;
    end

    // Peer capture, sampled mid-cycle where the byte is stable.
    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            acc = (byte_cnt == 0) ? tx_data : acc ^ tx_data;
            if (byte_cnt == 0) cap_btype = tx_data[7:4];
            if (byte_cnt == 0) cap_len[11:8] = tx_data[3:0];
            if (byte_cnt == 1) cap_len[7:0] = tx_data;
            if (byte_cnt >= 2 && byte_cnt - 2 < cap_len && byte_cnt - 2 < link_pkg::BUF_DEPTH)
                cap_pay[byte_cnt - 2] = tx_data;
            byte_cnt = byte_cnt + 1;
            if (byte_cnt >= 3 && byte_cnt == cap_len + 3) begin
                check("tx_checksum", acc, 8'h00);   // XOR over the whole frame.
                frames = frames + 1;
                byte_cnt = 0;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
            fails = fails + 1;
            test_errs = test_errs + 1;
        end
    endtask

    task apb_access(input logic wr, input link_pkg::apb_addr_t addr,
                    input link_pkg::apb_data_t data,
                    output link_pkg::apb_data_t rd, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rd = prdata;
        err = pslverr;
        check("pready", pready, 1'b1);    // No wait states.
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic drive_frame(input link_pkg::btype_t bt, input link_pkg::dlen_t len,
                               input logic bad);
        link_pkg::byte_t q[$];
        link_pkg::byte_t sum;
        int i;
        q.push_back({bt, len[11:8]});
        q.push_back(len[7:0]);
        for (i = 0; i < len; i++) begin
            rx_model[i % link_pkg::BUF_DEPTH] = link_pkg::byte_t'($random(seed));
            q.push_back(rx_model[i % link_pkg::BUF_DEPTH]);
        end
        sum = '0;
        foreach (q[j]) sum = sum ^ q[j];
        q.push_back(bad ? ~sum : sum);  // Corrupted on request.
        foreach (q[j]) begin
            rx_data = q[j];
            rx_valid = 1'b1;
            @(posedge clk);
            #1;
        end
        rx_valid = 1'b0;
    endtask

    task automatic fill_txbuf(input int start, input int len);
        link_pkg::apb_data_t rd;
        logic err;
        int i;
        int idx;
        for (i = 0; i < len; i++) begin
            idx = (start + i) % link_pkg::BUF_DEPTH;
            tx_model[idx] = link_pkg::byte_t'($random(seed));
            apb_access(1'b1, link_pkg::apb_addr_t'(link_pkg::TXBUF_BASE + 4 * idx),
                       tx_model[idx], rd, err);
            check("pslverr", err, 0);
        end
    endtask

    task automatic run_send(input int n_exp, input logic fail_exp, input string replies);
        link_pkg::apb_data_t st;
        logic err;
        int first;
        int k;
        int i;
        first = frames;
        k = 0;
        apb_access(1'b1, link_pkg::REG_CTRL, 32'h1, st, err);
        st = '0;
        while (!st[1]) begin
            if (frames > first + k) begin
                check("tx_btype", cap_btype, exp_btype);
                check("tx_len", cap_len, exp_len);
                for (i = 0; i < exp_len; i++)
                    check("tx_payload", cap_pay[i],
                          tx_model[(exp_addr + i) % link_pkg::BUF_DEPTH]);
                if (k < replies.len() && replies[k] == "A")
                    drive_frame(link_pkg::BT_ACK, '0, 1'b0);
                else if (k < replies.len() && replies[k] == "N")
                    drive_frame(link_pkg::BT_NAK, '0, 1'b0);
                k++;
            end
            apb_access(1'b0, link_pkg::REG_STATUS, 32'h0, st, err);
        end
        check("frames", frames - first, n_exp);
        check("status_fail", st[2], fail_exp);
    endtask

    task automatic run_inject(input link_pkg::btype_t bt, input link_pkg::dlen_t len,
                              input logic bad, input logic answered,
                              input link_pkg::btype_t ans_bt);
        link_pkg::apb_data_t st;
        logic err;
        int first;
        int i;
        first = frames;
        drive_frame(bt, len, bad);
        if (answered) begin
            while (frames == first) begin
                @(posedge clk);
                #1;
            end
            check("answer_btype", cap_btype, ans_bt);
            check("answer_len", cap_len, 0);
            st = '0;
            while (!st[3]) apb_access(1'b0, link_pkg::REG_STATUS, 32'h0, st, err);
            check("read_btype", st[7:4], bad ? link_pkg::BT_ERROR : bt);
            for (i = 0; i < len && !bad; i++) begin
                apb_access(1'b0, link_pkg::apb_addr_t'(link_pkg::RXBUF_BASE + 4 * i),
                           32'h0, st, err);
                check("rx_buffer", st, rx_model[i]);
            end
        end else begin
            repeat (link_pkg::ANS_TIMEOUT) @(posedge clk);     // Answer window.
            #1;
            apb_access(1'b0, link_pkg::REG_STATUS, 32'h0, st, err);
            check("answers", frames - first, 0);
            check("read_valid", st[3], 0);
        end
    endtask

    initial begin
        wait (n_tests > 0);
        repeat (n_tests * link_pkg::MAX_TRIES * (link_pkg::ANS_TIMEOUT + 200)) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 n_tests * link_pkg::MAX_TRIES * (link_pkg::ANS_TIMEOUT + 200));
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int fd;
        int rc;
        int n_done;
        int n_bad;
        string cmd;
        string line;
        string name;
        string replies;
        logic [31:0] a, d, m, e, f, g;
        link_pkg::apb_data_t rd;
        logic err;
        clk = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        tx_ready = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        n_done = 0;
        n_bad = 0;
        fd = $fopen("link_vectors.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the vector file link_vectors.txt");
            fails++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (line.len() > 0 && line[0] == "E") n_tests++;
            end
            $fclose(fd);
            fd = $fopen("link_vectors.txt", "r");
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd[0] == "#") begin
                rc = $fgets(line, fd);
            end else if (cmd == "W") begin
                rc = $fscanf(fd, "%h %h %h", a, d, e);
                if (e == 0 && a == link_pkg::REG_BTYPE) exp_btype = d[3:0];
                if (e == 0 && a == link_pkg::REG_DLEN) exp_len = d[11:0];
                if (e == 0 && a == link_pkg::REG_ADDR) exp_addr = d[11:0];
                if (e == 0 && a[11:8] == 4'h1) tx_model[a[7:2]] = d[7:0];
                apb_access(1'b1, a[11:0], d, rd, err);
                check("pslverr", err, e);
            end else if (cmd == "R") begin
                rc = $fscanf(fd, "%h %h %h %h", a, d, m, e);
                apb_access(1'b0, a[11:0], 32'h0, rd, err);
                check("prdata", rd & m, d & m);
                check("pslverr", err, e);
            end else if (cmd == "F") begin
                rc = $fscanf(fd, "%h %h", a, d);
                fill_txbuf(a, d);
            end else if (cmd == "S") begin
                rc = $fscanf(fd, "%h %h %s", a, d, replies);
                run_send(a, d[0], replies);
            end else if (cmd == "I") begin
                rc = $fscanf(fd, "%h %h %h %h %h", a, d, e, f, g);
                run_inject(a[3:0], d[11:0], e[0], f[0], g[3:0]);
            end else if (cmd == "E") begin
                rc = $fscanf(fd, "%s", name);
                n_done++;
                if (test_errs != 0) n_bad++;
                $display("test %0d %s: %0d errors", n_done, name, test_errs);
                test_errs = 0;
            end else begin
                $display("Error: unknown command %s in the vector file", cmd);
                fails++;
            end
        end
        if (fd != 0) $fclose(fd);
        if (n_done == 0) begin
            $display("Error: no test was run");
            fails++;
        end
        if (DUT.u_assertions.err_cnt != 0) begin
            $display("Error: %0d assertion failures", DUT.u_assertions.err_cnt);
            fails = fails + DUT.u_assertions.err_cnt;
        end
        $display("%0d tests, %0d with errors, %0d errors in total", n_done, n_bad, fails);
        if (fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- link_vectors.txt
# W addr data pslverr | R addr expected mask pslverr | F start count (random tx bytes)
# S frames fail replies (A ack, N nak, - silent) | I btype len bad answers answer_btype | E name
W 004 00000006 0
W 008 00000023 0
W 00c 00000015 0
W 104 000000a5 0
R 004 00000006 0000000f 0
R 008 00000023 00000fff 0
R 00c 00000015 00000fff 0
R 104 000000a5 000000ff 0
W 300 00000001 1
R 014 00000000 00000000 1
E reg_access
F 03c 8
W 008 00000008 0
W 00c 0000003c 0
S 1 0 A
R 010 00000002 00000007 0
E send_ack
F 010 4
W 004 00000005 0
W 008 00000004 0
W 00c 00000010 0
S 2 0 NA
R 010 00000002 00000007 0
E send_nak_ack
F 020 2
W 004 00000007 0
W 008 00000002 0
W 00c 00000020 0
S a 1 -
R 010 00000006 00000007 0
E silent_peer
I 6 8 0 1 1
W 000 00000002 0
R 010 00000000 00000008 0
E incoming_dparam
I 6 5 1 1 2
W 000 00000002 0
I d 4 0 0 0
R 010 00000000 00000008 0
E bad_and_unanswered

//--- sim.f
link_pkg.sv
link_arq_ctrl.sv
link_tx_framer.sv
link_rx_parser.sv
link_apb_regs.sv
link_top.sv
link_assertions.sv
link_tb.sv

//--- Bender.yml
package:
  name: link_arq

sources:
  - link_pkg.sv
  - link_arq_ctrl.sv
  - link_tx_framer.sv
  - link_rx_parser.sv
  - link_apb_regs.sv
  - link_top.sv
  - target: simulation
    files:
      - link_assertions.sv
      - link_tb.sv
